// File: vlog.f
hpdmc_pkg.sv
hpdmc_banktimer.sv
hpdmc_datactl.sv
hpdmc_sched.sv
hpdmc_csr.sv
hpdmc_top.sv
tb_hpdmc.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the hpdmc testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_hpdmc -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_hpdmc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_hpdmc.sv
// testbench for the SDRAM command-timing core.
// random requests are checked cycle by cycle against a model of the timing rules.
`timescale 1ns/1ps

module tb_hpdmc;

	localparam int RST_CYCLES = 4;
	localparam int TIMEOUT = 40;
	localparam int NUM_REQ = 50;
	localparam int MAX_CYC = 8192;

	logic sys_clk;
	logic sdram_rst;
	logic psel;
	logic penable;
	logic pwrite;
	hpdmc_pkg::apb_addr_t paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic req_valid;
	hpdmc_pkg::cmd_op_t req_op;
	hpdmc_pkg::bank_t req_bank;
	logic req_ready;
	logic cmd_read;
	logic cmd_write;
	logic cmd_precharge;
	hpdmc_pkg::bank_t cmd_bank;
	logic ack;
	logic direction;
	logic direction_r;

	int seed;
	int cyc = 0;
	int err_cnt = 0;
	int n_cmds = 0;
	int cur_cas = 0;
	int cur_wr = 1;
	// strobe history used by the timing model.
	int last_rw = -100;
	int last_wr = -100;
	int last_rd = -100;
	int last_rd_cas = 0;
	int bank_rd [4] = '{-100, -100, -100, -100};
	int bank_wr [4] = '{-100, -100, -100, -100};
	int bank_wr_tw [4] = '{0, 0, 0, 0};
	// expected per-cycle levels, filled when a strobe is seen.
	bit exp_ack [MAX_CYC];
	bit exp_dir [MAX_CYC];
	bit exp_dir_r [MAX_CYC];
	// request in flight, as accepted by the scheduler.
	int acc_cyc = -1;
	int exp_issue = -1;
	hpdmc_pkg::cmd_op_t exp_op;
	hpdmc_pkg::bank_t exp_bank;
	logic [31:0] rdata;
	logic [2:0] cfg [4] = '{3'b000, 3'b111, 3'b110, 3'b011};

	hpdmc_top #(
		.NUM_BANKS_P(hpdmc_pkg::NUM_BANKS)
	) uut (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_bank(req_bank),
		.req_ready(req_ready),
		.cmd_read(cmd_read),
		.cmd_write(cmd_write),
		.cmd_precharge(cmd_precharge),
		.cmd_bank(cmd_bank),
		.ack(ack),
		.direction(direction),
		.direction_r(direction_r)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// cycle index, stable when sampled at the falling edge.
	always @(posedge sys_clk)
		cyc <= cyc + 1;

	task automatic stop_on_error(string line);
		err_cnt++;
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "test stopped at first error");
	endtask

	function automatic string mismatch_line(string name, int expected, int actual);
		return $sformatf("Mismatch at %0t: %s expected %0d, actual %0d",
			$time, name, expected, actual);
	endfunction

	// earliest cycle in which a strobe for op may be seen.
	// a safe flag returns n cycles after the registering edge,
	// so the next strobe shows n + 1 cycles after the last one.
	function automatic int earliest_issue(hpdmc_pkg::cmd_op_t op, hpdmc_pkg::bank_t b);
		int t;
		case (op)
			hpdmc_pkg::OP_READ: t = last_rw + 6;
			hpdmc_pkg::OP_WRITE: begin
				t = last_wr + 4;
				if (last_rd + 6 + last_rd_cas > t)
					t = last_rd + 6 + last_rd_cas;
			end
			default: begin
				t = bank_rd[b] + 5;
				if (bank_wr[b] + 6 + bank_wr_tw[b] > t)
					t = bank_wr[b] + 6 + bank_wr_tw[b];
			end
		endcase
		return t;
	endfunction

	// log a strobe and schedule its ack and direction windows.
	function automatic void record_strobe(int c, hpdmc_pkg::cmd_op_t op,
		hpdmc_pkg::bank_t b);
		n_cmds++;
		if (op == hpdmc_pkg::OP_READ) begin
			last_rw = c;
			last_rd = c;
			last_rd_cas = cur_cas;
			bank_rd[b] = c;
			exp_ack[c + 5 + cur_cas] = 1'b1;
		end else if (op == hpdmc_pkg::OP_WRITE) begin
			last_rw = c;
			last_wr = c;
			bank_wr[b] = c;
			bank_wr_tw[b] = cur_wr;
			exp_ack[c + 2] = 1'b1;
			for (int i = 2; i <= 6; i++)
				exp_dir[c + i] = 1'b1;
			for (int i = 1; i <= 6; i++)
				exp_dir_r[c + i] = 1'b1;
		end
	endfunction

	// compare every output against the model each cycle.
	always @(negedge sys_clk) begin
		bit is_issue;
		bit exp_rd;
		bit exp_wr;
		bit exp_pre;
		bit exp_ready;
		if (cyc >= RST_CYCLES) begin
			is_issue = (cyc == exp_issue);
			exp_rd = is_issue && (exp_op == hpdmc_pkg::OP_READ);
			exp_wr = is_issue && (exp_op == hpdmc_pkg::OP_WRITE);
			exp_pre = is_issue && (exp_op == hpdmc_pkg::OP_PRECHARGE);
			exp_ready = !(cyc >= acc_cyc && cyc <= exp_issue);
			assert (cmd_read == exp_rd)
				else stop_on_error(mismatch_line("cmd_read", int'(exp_rd), int'(cmd_read)));
			assert (cmd_write == exp_wr)
				else stop_on_error(mismatch_line("cmd_write", int'(exp_wr), int'(cmd_write)));
			assert (cmd_precharge == exp_pre)
				else stop_on_error(mismatch_line("cmd_precharge", int'(exp_pre),
					int'(cmd_precharge)));
			if (is_issue)
				assert (cmd_bank == exp_bank)
					else stop_on_error(mismatch_line("cmd_bank", int'(exp_bank),
						int'(cmd_bank)));
			assert (req_ready == exp_ready)
				else stop_on_error(mismatch_line("req_ready", int'(exp_ready),
					int'(req_ready)));
			assert (ack == exp_ack[cyc])
				else stop_on_error(mismatch_line("ack", int'(exp_ack[cyc]), int'(ack)));
			assert (direction == exp_dir[cyc])
				else stop_on_error(mismatch_line("direction", int'(exp_dir[cyc]),
					int'(direction)));
			assert (direction_r == exp_dir_r[cyc])
				else stop_on_error(mismatch_line("direction_r", int'(exp_dir_r[cyc]),
					int'(direction_r)));
			if (is_issue)
				record_strobe(cyc, exp_op, exp_bank);
		end
	end

	// APB transfers start on a falling edge.
	task automatic apb_write(hpdmc_pkg::apb_addr_t addr, logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge sys_clk);
		penable = 1'b1;
		// the slave has no wait states.
		#5;
		assert (pready == 1'b1)
			else stop_on_error(mismatch_line("pready", 1, int'(pready)));
		@(negedge sys_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		if (addr == hpdmc_pkg::ADDR_TIMING) begin
			cur_cas = int'(data[0]);
			cur_wr = int'(data[2:1]);
		end
	endtask

	task automatic apb_read(hpdmc_pkg::apb_addr_t addr, output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge sys_clk);
		penable = 1'b1;
		// prdata is combinational in the access phase.
		#5 data = prdata;
		assert (pready == 1'b1)
			else stop_on_error(mismatch_line("pready", 1, int'(pready)));
		@(negedge sys_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!req_ready && waited < TIMEOUT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!req_ready)
			stop_on_error("Timeout: req_ready stayed low, a request was never issued");
	endtask

	// one random request, accepted on the next rising edge.
	task automatic send_request();
		int r;
		int t;
		hpdmc_pkg::cmd_op_t op;
		r = $random(seed);
		repeat (r[6:5]) @(negedge sys_clk);
		wait_ready();
		case (r[3:2])
			2'd1: op = hpdmc_pkg::OP_WRITE;
			2'd2: op = hpdmc_pkg::OP_PRECHARGE;
			default: op = hpdmc_pkg::OP_READ;
		endcase
		req_valid = 1'b1;
		req_op = op;
		req_bank = r[1:0];
		t = earliest_issue(op, r[1:0]);
		acc_cyc <= cyc + 1;
		exp_issue <= (t > cyc + 1) ? t : cyc + 1;
		exp_op <= op;
		exp_bank <= r[1:0];
		@(negedge sys_clk);
		req_valid = 1'b0;
	endtask

	initial begin
		seed = 40;
		sdram_rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = hpdmc_pkg::ADDR_TIMING;
		pwdata = 32'd0;
		req_valid = 1'b0;
		req_op = hpdmc_pkg::OP_READ;
		req_bank = 2'd0;
		repeat (RST_CYCLES) @(negedge sys_clk);
		sdram_rst = 1'b0;
		// reset value, cas 0 and write recovery 1.
		apb_read(hpdmc_pkg::ADDR_TIMING, rdata);
		assert (rdata == 32'd2)
			else stop_on_error(mismatch_line("prdata", 2, int'(rdata)));
		for (int p = 0; p < 4; p++) begin
			apb_write(hpdmc_pkg::ADDR_TIMING, {29'd0, cfg[p]});
			apb_read(hpdmc_pkg::ADDR_TIMING, rdata);
			assert (rdata == {29'd0, cfg[p]})
				else stop_on_error(mismatch_line("prdata", int'(cfg[p]), int'(rdata)));
			repeat (NUM_REQ) send_request();
			// let acks, direction and timers run out before the next setting.
			wait_ready();
			repeat (12) @(negedge sys_clk);
		end
		apb_read(hpdmc_pkg::ADDR_COUNT, rdata);
		assert (int'(rdata) == n_cmds)
			else stop_on_error(mismatch_line("prdata", n_cmds, int'(rdata)));
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: hpdmc_top.sv
// SDRAM command-timing core.
// scheduler, data-path timing and APB configuration registers.
`timescale 1ns/1ps

module hpdmc_top #(
	parameter int NUM_BANKS_P = hpdmc_pkg::NUM_BANKS
) (
	input logic sys_clk,
	input logic sdram_rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input hpdmc_pkg::apb_addr_t paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	input logic req_valid,
	input hpdmc_pkg::cmd_op_t req_op,
	input hpdmc_pkg::bank_t req_bank,
	output logic req_ready,
	output logic cmd_read,
	output logic cmd_write,
	output logic cmd_precharge,
	output hpdmc_pkg::bank_t cmd_bank,
	output logic ack,
	output logic direction,
	output logic direction_r
);

	logic read_safe;
	logic write_safe;
	hpdmc_pkg::bank_mask_t precharge_safe;
	hpdmc_pkg::bank_mask_t concerned_bank;
	logic tim_cas;
	hpdmc_pkg::tim_wr_t tim_wr;
	logic issued;

	// any issued command bumps the counter.
	assign issued = cmd_read | cmd_write | cmd_precharge;

	// one-hot back to a bank index.
	assign cmd_bank = {concerned_bank[3] | concerned_bank[2],
		concerned_bank[3] | concerned_bank[1]};

	hpdmc_sched sched (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_bank(req_bank),
		.req_ready(req_ready),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.read(cmd_read),
		.write(cmd_write),
		.precharge(cmd_precharge),
		.concerned_bank(concerned_bank)
	);

	hpdmc_datactl #(
		.NUM_BANKS_P(NUM_BANKS_P)
	) datactl (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.read(cmd_read),
		.write(cmd_write),
		.concerned_bank(concerned_bank),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.ack(ack),
		.direction(direction),
		.direction_r(direction_r),
		.tim_cas(tim_cas),
		.tim_wr(tim_wr)
	);

	hpdmc_csr csr (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.issued(issued),
		.tim_cas(tim_cas),
		.tim_wr(tim_wr)
	);

endmodule

// File: hpdmc_csr.sv
// APB configuration slave.
// holds cas latency and write recovery and counts issued commands.
`timescale 1ns/1ps

module hpdmc_csr (
	input logic sys_clk,
	input logic sdram_rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input hpdmc_pkg::apb_addr_t paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	input logic issued,
	output logic tim_cas,
	output hpdmc_pkg::tim_wr_t tim_wr
);

	hpdmc_pkg::cnt_t count;
	logic access;

	// no wait states.
	assign pready = 1'b1;
	assign access = psel & penable;

	// timing register, bit 0 cas, bits 2:1 write recovery.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			tim_cas <= 1'b0;
			tim_wr <= 2'd1;
		end else if (access && pwrite && (paddr == hpdmc_pkg::ADDR_TIMING)) begin
			tim_cas <= pwdata[0];
			tim_wr <= pwdata[2:1];
		end
	end

	// issued-command counter, wraps.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			count <= '0;
		else if (issued)
			count <= count + hpdmc_pkg::cnt_t'(1);
	end

	// read mux, only driven during a read access.
	always_comb begin
		prdata = 32'd0;
		if (access && !pwrite) begin
			case (paddr)
				hpdmc_pkg::ADDR_TIMING: prdata = {29'd0, tim_wr, tim_cas};
				hpdmc_pkg::ADDR_COUNT: prdata = {16'd0, count};
				default: prdata = 32'd0;
			endcase
		end
	end

endmodule

// File: hpdmc_sched.sv
// command scheduler.
// accepts one request at a time and issues it once the data path allows.
`timescale 1ns/1ps

module hpdmc_sched (
	input logic sys_clk,
	input logic sdram_rst,
	input logic req_valid,
	input hpdmc_pkg::cmd_op_t req_op,
	input hpdmc_pkg::bank_t req_bank,
	output logic req_ready,
	input logic read_safe,
	input logic write_safe,
	input hpdmc_pkg::bank_mask_t precharge_safe,
	output logic read,
	output logic write,
	output logic precharge,
	output hpdmc_pkg::bank_mask_t concerned_bank
);

	hpdmc_pkg::sched_state_t state;
	hpdmc_pkg::cmd_op_t op_q;
	hpdmc_pkg::bank_t bank_q;
	logic pending;
	logic safe_sel;
	logic issue;

	// latched request.
	always_ff @(posedge sys_clk) begin
		if (req_valid && req_ready) begin
			op_q <= req_op;
			bank_q <= req_bank;
		end
	end

	// pick the safe flag for the held op.
	always_comb begin
		case (op_q)
			hpdmc_pkg::OP_READ: safe_sel = read_safe;
			hpdmc_pkg::OP_WRITE: safe_sel = write_safe;
			hpdmc_pkg::OP_PRECHARGE: safe_sel = precharge_safe[bank_q];
			default: safe_sel = 1'b0;
		endcase
	end

	assign pending = (state == hpdmc_pkg::WAIT_SAFE);
	assign issue = pending & safe_sel;
	assign req_ready = (state == hpdmc_pkg::IDLE);

	// one-cycle strobes, sampled on the edge that ends the wait.
	assign read = issue & (op_q == hpdmc_pkg::OP_READ);
	assign write = issue & (op_q == hpdmc_pkg::OP_WRITE);
	assign precharge = issue & (op_q == hpdmc_pkg::OP_PRECHARGE);

	// one-hot bank for the data path and its timers.
	assign concerned_bank = hpdmc_pkg::bank_mask_t'(1) << bank_q;

	// the data path keeps its own timers.
	// so a new request may be taken right after issue.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state <= hpdmc_pkg::IDLE;
		end else begin
			case (state)
				hpdmc_pkg::IDLE: begin
					if (req_valid)
						state <= hpdmc_pkg::WAIT_SAFE;
				end
				hpdmc_pkg::WAIT_SAFE: begin
					if (issue)
						state <= hpdmc_pkg::IDLE;
				end
				default: state <= hpdmc_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: hpdmc_datactl.sv
// data-path timing control.
// tracks bus turnaround, acknowledges transfers and drives DQ/DQS direction.
`timescale 1ns/1ps

module hpdmc_datactl #(
	parameter int NUM_BANKS_P = hpdmc_pkg::NUM_BANKS
) (
	input logic sys_clk,
	input logic sdram_rst,
	input logic read,
	input logic write,
	input hpdmc_pkg::bank_mask_t concerned_bank,
	output logic read_safe,
	output logic write_safe,
	output hpdmc_pkg::bank_mask_t precharge_safe,
	output logic ack,
	output logic direction,
	output logic direction_r,
	input logic tim_cas,
	input hpdmc_pkg::tim_wr_t tim_wr
);

	logic [2:0] read_safe_cnt;
	logic [2:0] write_safe_cnt;
	logic ack_rd3;
	logic ack_rd2;
	logic ack_rd1;
	logic ack_rd0;
	logic ack_pre;
	logic write_d;
	logic [2:0] dir_cnt;

	// read_safe high means a read may be registered next cycle.
	// both reads and writes block reads for 5 cycles.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			read_safe_cnt <= 3'd0;
			read_safe <= 1'b1;
		end else if (read || write) begin
			read_safe_cnt <= 3'd5;
			read_safe <= 1'b0;
		end else begin
			if (read_safe_cnt == 3'd1)
				read_safe <= 1'b1;
			if (!read_safe)
				read_safe_cnt <= read_safe_cnt - 3'd1;
		end
	end

	// write_safe, same scheme.
	// after a read the bus turns around at CL+3, i.e. 5 or 6 cycles.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			write_safe_cnt <= 3'd0;
			write_safe <= 1'b1;
		end else if (read) begin
			write_safe_cnt <= tim_cas ? 3'd6 : 3'd5;
			write_safe <= 1'b0;
		end else if (write) begin
			write_safe_cnt <= 3'd3;
			write_safe <= 1'b0;
		end else begin
			if (write_safe_cnt == 3'd1)
				write_safe <= 1'b1;
			if (!write_safe)
				write_safe_cnt <= write_safe_cnt - 3'd1;
		end
	end

	// read ack delay line.
	// entry point moves one stage earlier for the longer cas latency.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			ack_rd3 <= 1'b0;
			ack_rd2 <= 1'b0;
			ack_rd1 <= 1'b0;
			ack_rd0 <= 1'b0;
		end else begin
			ack_rd3 <= tim_cas & read;
			ack_rd2 <= tim_cas ? ack_rd3 : read;
			ack_rd1 <= ack_rd2;
			ack_rd0 <= ack_rd1;
		end
	end

	// common output stage, writes join here for their 2 cycle ack.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			ack_pre <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack_pre <= ack_rd0 | write;
			ack <= ack_pre;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			write_d <= 1'b0;
		else
			write_d <= write;
	end

	// direction is the DQ/DQS output enable and must not glitch.
	// it is a plain flop, held for 5 cycles by a counter.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			dir_cnt <= 3'd0;
			direction <= 1'b0;
		end else if (write_d) begin
			dir_cnt <= 3'd5;
			direction <= 1'b1;
		end else begin
			if (dir_cnt == 3'd1)
				direction <= 1'b0;
			if (direction)
				dir_cnt <= dir_cnt - 3'd1;
		end
	end

	// early enable, one cycle ahead of the window.
	// lets DQS settle before the first edge.
	assign direction_r = write_d | (|dir_cnt);

	// one precharge guard per bank, strobes gated by the bank bit.
	for (genvar i = 0; i < NUM_BANKS_P; i++) begin : gen_bank
		hpdmc_banktimer banktimer (
			.sys_clk(sys_clk),
			.sdram_rst(sdram_rst),
			.tim_cas(tim_cas),
			.tim_wr(tim_wr),
			.read(read & concerned_bank[i]),
			.write(write & concerned_bank[i]),
			.precharge_safe(precharge_safe[i])
		);
	end

endmodule

// File: hpdmc_banktimer.sv
// per-bank precharge guard.
// holds precharge_safe low while read or write data may still be in flight.
`timescale 1ns/1ps

module hpdmc_banktimer (
	input logic sys_clk,
	input logic sdram_rst,
	input logic tim_cas,
	input hpdmc_pkg::tim_wr_t tim_wr,
	input logic read,
	input logic write,
	output logic precharge_safe
);

	// cycles left before the bank may be closed.
	logic [3:0] counter;

	// read-to-precharge spacing is fixed by the burst length.
	// cas latency only shifts the data, not the precharge point.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			counter <= 4'd0;
			precharge_safe <= 1'b1;
		end else if (read) begin
			counter <= 4'd4;
			precharge_safe <= 1'b0;
		end else if (write) begin
			// burst plus write recovery.
			counter <= 4'd5 + {2'b00, tim_wr};
			precharge_safe <= 1'b0;
		end else begin
			if (counter == 4'd1)
				precharge_safe <= 1'b1;
			// count only while the bank is held.
			if (!precharge_safe)
				counter <= counter - 4'd1;
		end
	end

endmodule

// File: hpdmc_pkg.sv
// shared types and constants for the SDRAM command-timing core.
// covers bank indexing, timing fields, request ops and the APB map.
package hpdmc_pkg;

	// number of SDRAM banks tracked by the data path.
	localparam int NUM_BANKS = 4;

	typedef logic [1:0] bank_t;
	typedef logic [NUM_BANKS-1:0] bank_mask_t;

	// write recovery, in cycles beyond the base delay.
	typedef logic [1:0] tim_wr_t;

	typedef enum logic [1:0] {
		OP_READ = 2'd0,
		OP_WRITE = 2'd1,
		OP_PRECHARGE = 2'd2
	} cmd_op_t;

	typedef enum logic {
		IDLE = 1'b0,
		WAIT_SAFE = 1'b1
	} sched_state_t;

	// APB register map.
	typedef logic [3:0] apb_addr_t;
	localparam apb_addr_t ADDR_TIMING = 4'd0;
	localparam apb_addr_t ADDR_COUNT = 4'd4;

	typedef logic [15:0] cnt_t;

endpackage
